//--- Bender.yml
package:
  name: piano_control_unit

sources:
  - hdl/piano_ctrl_pkg.sv
  - hdl/menu_sequencer.sv
  - hdl/game_sequencer.sv
  - hdl/piano_control_unit.sv
  - target: test
    files:
      - tests/game_sequencer_properties.sv
      - tests/piano_checker.sv
      - tests/tb_piano_control_unit.sv

//--- hdl/game_sequencer.sv
// ----------------------------------------
// Genius and freestyle game sequencer
// ----------------------------------------
`timescale 1ns/1ps

module game_sequencer (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         start,
    input  logic                         enter,
    input  logic                         start_play,
    input  piano_ctrl_pkg::play_mode_t   mode,
    input  piano_ctrl_pkg::err_choice_t  err_choice,
    input  piano_ctrl_pkg::play_status_t status,
    output piano_ctrl_pkg::play_ctrl_t   play_ctrl,
    output piano_ctrl_pkg::state_code_t  game_state,
    output logic                         game_done
);

    piano_ctrl_pkg::state_code_t state;
    piano_ctrl_pkg::state_code_t next_state;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= piano_ctrl_pkg::ST_GAME_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            piano_ctrl_pkg::ST_GAME_IDLE: begin
                if (start_play) begin
                    next_state = piano_ctrl_pkg::ST_INIT_ELEMENTS;
                end
            end
            piano_ctrl_pkg::ST_INIT_ELEMENTS: begin
                // No valid mode falls back to the menu
                if (mode.genius) begin
                    next_state = piano_ctrl_pkg::ST_ROUND_START;
                end else if (mode.freestyle) begin
                    next_state = piano_ctrl_pkg::ST_FREE_WAIT;
                end else begin
                    next_state = piano_ctrl_pkg::ST_FINISH;
                end
            end
            piano_ctrl_pkg::ST_ROUND_START: begin
                if (status.show_timer_done) begin
                    next_state = piano_ctrl_pkg::ST_SHOW;
                end
            end
            piano_ctrl_pkg::ST_SHOW: next_state = piano_ctrl_pkg::ST_WAIT_SHOW;
            piano_ctrl_pkg::ST_WAIT_SHOW: begin
                if (status.beat_low) begin
                    next_state = status.address_is_round ? piano_ctrl_pkg::ST_NOTE_START
                                                         : piano_ctrl_pkg::ST_SHOW_NEXT;
                end
            end
            piano_ctrl_pkg::ST_SHOW_NEXT:  next_state = piano_ctrl_pkg::ST_SHOW;
            piano_ctrl_pkg::ST_NOTE_START: next_state = piano_ctrl_pkg::ST_WAIT_NOTE;
            piano_ctrl_pkg::ST_WAIT_NOTE: begin
                // Timeout beats a late press
                if (status.timeout) begin
                    next_state = piano_ctrl_pkg::ST_WRONG_TIME;
                end else if (status.note_pressed) begin
                    next_state = piano_ctrl_pkg::ST_PLAY_NOTE;
                end
            end
            piano_ctrl_pkg::ST_PLAY_NOTE: begin
                if (!status.note_pressed) begin
                    next_state = mode.genius ? piano_ctrl_pkg::ST_COMPARE
                                             : piano_ctrl_pkg::ST_FREE_WAIT;
                end
            end
            piano_ctrl_pkg::ST_COMPARE: begin
                if (!status.note_right) begin
                    next_state = piano_ctrl_pkg::ST_WRONG_NOTE;
                end else if (!status.timing_right) begin
                    next_state = piano_ctrl_pkg::ST_WRONG_TIME;
                end else if (status.address_is_round) begin
                    next_state = status.last_round ? piano_ctrl_pkg::ST_WON
                                                   : piano_ctrl_pkg::ST_ADVANCE_NOTE;
                end else begin
                    next_state = piano_ctrl_pkg::ST_NEXT_NOTE;
                end
            end
            piano_ctrl_pkg::ST_NEXT_NOTE:    next_state = piano_ctrl_pkg::ST_WAIT_NOTE;
            piano_ctrl_pkg::ST_ADVANCE_NOTE: next_state = piano_ctrl_pkg::ST_RECORD;
            piano_ctrl_pkg::ST_RECORD:       next_state = piano_ctrl_pkg::ST_CHECK_END;
            piano_ctrl_pkg::ST_CHECK_END: begin
                next_state = status.song_end ? piano_ctrl_pkg::ST_WON
                                             : piano_ctrl_pkg::ST_NEXT_ROUND;
            end
            piano_ctrl_pkg::ST_NEXT_ROUND: next_state = piano_ctrl_pkg::ST_ROUND_START;
            piano_ctrl_pkg::ST_WRONG_NOTE,
            piano_ctrl_pkg::ST_WRONG_TIME: next_state = piano_ctrl_pkg::ST_OPEN_ERROR;
            piano_ctrl_pkg::ST_OPEN_ERROR: next_state = piano_ctrl_pkg::ST_ERROR_MENU;
            piano_ctrl_pkg::ST_ERROR_MENU: begin
                // First choice set wins, none set keeps the menu up
                if (enter) begin
                    if (err_choice.retry_round) begin
                        next_state = piano_ctrl_pkg::ST_ROUND_START;
                    end else if (err_choice.retry_note) begin
                        next_state = piano_ctrl_pkg::ST_NOTE_START;
                    end else if (err_choice.replay_last) begin
                        next_state = piano_ctrl_pkg::ST_SHOW_LAST;
                    end
                end
            end
            piano_ctrl_pkg::ST_SHOW_LAST: begin
                if (status.beat_low) begin
                    next_state = piano_ctrl_pkg::ST_WAIT_NOTE;
                end
            end
            piano_ctrl_pkg::ST_WON: begin
                if (start) begin
                    next_state = piano_ctrl_pkg::ST_FINISH;
                end
            end
            piano_ctrl_pkg::ST_FINISH: next_state = piano_ctrl_pkg::ST_GAME_IDLE;
            piano_ctrl_pkg::ST_FREE_WAIT: begin
                if (status.note_pressed) begin
                    next_state = piano_ctrl_pkg::ST_PLAY_NOTE;
                end
            end
            default: next_state = piano_ctrl_pkg::ST_GAME_IDLE;
        endcase
    end

    // ----------------------------------------
    // Moore decode
    // ----------------------------------------
    always_comb begin
        play_ctrl = '0;
        case (state)
            piano_ctrl_pkg::ST_INIT_ELEMENTS: begin
                play_ctrl.clear_round       = 1'b1;
                play_ctrl.clear_reply_timer = 1'b1;
                play_ctrl.clear_show_timer  = 1'b1;
                play_ctrl.clear_beat        = 1'b1;
            end
            piano_ctrl_pkg::ST_ROUND_START: begin
                play_ctrl.clear_note       = 1'b1;
                play_ctrl.count_show_timer = 1'b1;
            end
            piano_ctrl_pkg::ST_SHOW: begin
                play_ctrl.clear_show_timer = 1'b1;
                play_ctrl.clear_beat       = 1'b1;
            end
            piano_ctrl_pkg::ST_WAIT_SHOW,
            piano_ctrl_pkg::ST_SHOW_LAST: begin
                play_ctrl.leds_from_memory = 1'b1;
                play_ctrl.leds_on          = 1'b1;
                play_ctrl.count_beat       = 1'b1;
            end
            piano_ctrl_pkg::ST_SHOW_NEXT,
            piano_ctrl_pkg::ST_ADVANCE_NOTE: play_ctrl.count_note = 1'b1;
            piano_ctrl_pkg::ST_NOTE_START: begin
                play_ctrl.clear_note        = 1'b1;
                play_ctrl.clear_reply_timer = 1'b1;
                play_ctrl.clear_show_timer  = 1'b1;
            end
            piano_ctrl_pkg::ST_WAIT_NOTE: begin
                play_ctrl.count_reply_timer = 1'b1;
                play_ctrl.clear_beat        = 1'b1;
                play_ctrl.player_turn       = 1'b1;
            end
            piano_ctrl_pkg::ST_PLAY_NOTE: begin
                play_ctrl.latch_note = 1'b1;
                play_ctrl.leds_on    = 1'b1;
                play_ctrl.sound      = 1'b1;
                play_ctrl.count_beat = 1'b1;
            end
            piano_ctrl_pkg::ST_COMPARE: play_ctrl.latch_error = 1'b1;
            piano_ctrl_pkg::ST_NEXT_NOTE: begin
                play_ctrl.count_note        = 1'b1;
                play_ctrl.clear_reply_timer = 1'b1;
            end
            piano_ctrl_pkg::ST_CHECK_END: begin
                play_ctrl.clear_reply_timer = 1'b1;
                play_ctrl.clear_beat        = 1'b1;
            end
            piano_ctrl_pkg::ST_NEXT_ROUND: play_ctrl.count_round = 1'b1;
            piano_ctrl_pkg::ST_WRONG_NOTE,
            piano_ctrl_pkg::ST_WRONG_TIME: begin
                play_ctrl.clear_reply_timer = 1'b1;
                play_ctrl.clear_beat        = 1'b1;
                play_ctrl.lost              = 1'b1;
            end
            piano_ctrl_pkg::ST_OPEN_ERROR: play_ctrl.open_error_menu  = 1'b1;
            piano_ctrl_pkg::ST_ERROR_MENU: play_ctrl.error_menu_shown = 1'b1;
            piano_ctrl_pkg::ST_WON:        play_ctrl.won              = 1'b1;
            // Metronome keeps running between free presses
            piano_ctrl_pkg::ST_FREE_WAIT:  play_ctrl.count_beat       = 1'b1;
            default: play_ctrl = '0;
        endcase
    end

    assign game_state = state;
    assign game_done  = (state == piano_ctrl_pkg::ST_FINISH);

endmodule

//--- hdl/menu_sequencer.sv
// ----------------------------------------
// Setup menu sequencer
// ----------------------------------------
`timescale 1ns/1ps

module menu_sequencer (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        start,
    input  logic                        enter,
    input  piano_ctrl_pkg::play_mode_t  mode,
    input  logic                        game_done,
    input  piano_ctrl_pkg::state_code_t game_state,
    output logic                        start_play,
    output piano_ctrl_pkg::menu_ctrl_t  menu_ctrl,
    output piano_ctrl_pkg::state_code_t db_state
);

    piano_ctrl_pkg::state_code_t state;
    piano_ctrl_pkg::state_code_t next_state;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= piano_ctrl_pkg::ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ----------------------------------------
    // Page walk
    // ----------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            piano_ctrl_pkg::ST_IDLE: begin
                if (start) begin
                    next_state = piano_ctrl_pkg::ST_MENU_INIT;
                end
            end
            piano_ctrl_pkg::ST_MENU_INIT: begin
                next_state = piano_ctrl_pkg::ST_WAIT_MODE;
            end
            piano_ctrl_pkg::ST_WAIT_MODE: begin
                if (enter) begin
                    next_state = piano_ctrl_pkg::ST_WAIT_BPM;
                end
            end
            piano_ctrl_pkg::ST_WAIT_BPM: begin
                if (enter) begin
                    next_state = piano_ctrl_pkg::ST_WAIT_KEY;
                end
            end
            piano_ctrl_pkg::ST_WAIT_KEY: begin
                // Freestyle has no song to pick
                if (enter) begin
                    next_state = mode.freestyle ? piano_ctrl_pkg::ST_IN_GAME
                                                : piano_ctrl_pkg::ST_WAIT_SONG;
                end
            end
            piano_ctrl_pkg::ST_WAIT_SONG: begin
                if (enter) begin
                    next_state = piano_ctrl_pkg::ST_IN_GAME;
                end
            end
            piano_ctrl_pkg::ST_IN_GAME: begin
                if (game_done) begin
                    next_state = piano_ctrl_pkg::ST_MENU_INIT;
                end
            end
            default: next_state = piano_ctrl_pkg::ST_IDLE;
        endcase
    end

    // ----------------------------------------
    // Moore decode
    // ----------------------------------------
    always_comb begin
        menu_ctrl = '0;
        case (state)
            piano_ctrl_pkg::ST_IDLE: begin
                menu_ctrl.clear_registers = 1'b1;
                menu_ctrl.clear_options   = 1'b1;
            end
            piano_ctrl_pkg::ST_MENU_INIT: menu_ctrl.open_menu = 1'b1;
            piano_ctrl_pkg::ST_WAIT_MODE: begin
                menu_ctrl.show_menu = 1'b1;
                menu_ctrl.menu_page = piano_ctrl_pkg::PAGE_MODE;
                menu_ctrl.load_mode = 1'b1;
            end
            piano_ctrl_pkg::ST_WAIT_BPM: begin
                menu_ctrl.show_menu = 1'b1;
                menu_ctrl.menu_page = piano_ctrl_pkg::PAGE_TEMPO;
                menu_ctrl.load_bpm  = 1'b1;
            end
            piano_ctrl_pkg::ST_WAIT_KEY: begin
                menu_ctrl.show_menu = 1'b1;
                menu_ctrl.menu_page = piano_ctrl_pkg::PAGE_KEY;
                menu_ctrl.load_key  = 1'b1;
            end
            piano_ctrl_pkg::ST_WAIT_SONG: begin
                menu_ctrl.show_menu = 1'b1;
                menu_ctrl.menu_page = piano_ctrl_pkg::PAGE_SONG;
                menu_ctrl.load_song = 1'b1;
            end
            default: menu_ctrl = '0;
        endcase
    end

    assign start_play = (state == piano_ctrl_pkg::ST_IN_GAME);

    // Game code takes over the debug display during play
    assign db_state = start_play ? game_state : state;

endmodule

//--- hdl/piano_control_unit.sv
// ----------------------------------------
// Piano control unit
// ----------------------------------------
`timescale 1ns/1ps

module piano_control_unit (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         start,
    input  logic                         enter,
    input  piano_ctrl_pkg::play_mode_t   mode,
    input  piano_ctrl_pkg::err_choice_t  err_choice,
    input  piano_ctrl_pkg::play_status_t status,
    output piano_ctrl_pkg::menu_ctrl_t   menu_ctrl,
    output piano_ctrl_pkg::play_ctrl_t   play_ctrl,
    output piano_ctrl_pkg::state_code_t  db_state
);

    // Menu to game hand-off
    logic                        start_play;
    logic                        game_done;
    piano_ctrl_pkg::state_code_t game_state;

    menu_sequencer menu_seq (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .enter      (enter),
        .mode       (mode),
        .game_done  (game_done),
        .game_state (game_state),
        .start_play (start_play),
        .menu_ctrl  (menu_ctrl),
        .db_state   (db_state)
    );

    game_sequencer game_seq (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .enter      (enter),
        .start_play (start_play),
        .mode       (mode),
        .err_choice (err_choice),
        .status     (status),
        .play_ctrl  (play_ctrl),
        .game_state (game_state),
        .game_done  (game_done)
    );

endmodule

//--- hdl/piano_ctrl_pkg.sv
// ----------------------------------------
// Piano control shared types
// ----------------------------------------
package piano_ctrl_pkg;

    typedef logic [5:0] state_code_t;

    // Menu states
    localparam state_code_t ST_IDLE      = 6'h00;
    localparam state_code_t ST_MENU_INIT = 6'h1C;
    localparam state_code_t ST_WAIT_MODE = 6'h1D;
    localparam state_code_t ST_WAIT_BPM  = 6'h1E;
    localparam state_code_t ST_WAIT_KEY  = 6'h1F;
    localparam state_code_t ST_WAIT_SONG = 6'h20;
    // Menu parks here while the game runs, never seen on db_state
    localparam state_code_t ST_IN_GAME   = 6'h3D;

    // Game states
    localparam state_code_t ST_INIT_ELEMENTS = 6'h01;
    localparam state_code_t ST_ROUND_START   = 6'h02;
    localparam state_code_t ST_SHOW          = 6'h03;
    localparam state_code_t ST_WAIT_SHOW     = 6'h04;
    localparam state_code_t ST_SHOW_NEXT     = 6'h05;
    localparam state_code_t ST_NOTE_START    = 6'h06;
    localparam state_code_t ST_WAIT_NOTE     = 6'h07;
    localparam state_code_t ST_COMPARE       = 6'h09;
    localparam state_code_t ST_WON           = 6'h0A;
    localparam state_code_t ST_NEXT_NOTE     = 6'h0B;
    localparam state_code_t ST_ADVANCE_NOTE  = 6'h13;
    localparam state_code_t ST_WRONG_NOTE    = 6'h14;
    localparam state_code_t ST_WRONG_TIME    = 6'h15;
    localparam state_code_t ST_PLAY_NOTE     = 6'h17;
    localparam state_code_t ST_SHOW_LAST     = 6'h18;
    localparam state_code_t ST_NEXT_ROUND    = 6'h19;
    localparam state_code_t ST_CHECK_END     = 6'h1A;
    localparam state_code_t ST_RECORD        = 6'h1B;
    localparam state_code_t ST_OPEN_ERROR    = 6'h21;
    localparam state_code_t ST_ERROR_MENU    = 6'h22;
    localparam state_code_t ST_FREE_WAIT     = 6'h23;
    localparam state_code_t ST_FINISH        = 6'h3E;
    localparam state_code_t ST_GAME_IDLE     = 6'h3F;

    // Menu page select
    localparam logic [1:0] PAGE_MODE  = 2'd0;
    localparam logic [1:0] PAGE_TEMPO = 2'd1;
    localparam logic [1:0] PAGE_KEY   = 2'd2;
    localparam logic [1:0] PAGE_SONG  = 2'd3;

    typedef struct packed {
        logic freestyle;
        logic genius;
    } play_mode_t;

    typedef struct packed {
        logic retry_round;
        logic retry_note;
        logic replay_last;
    } err_choice_t;

    typedef struct packed {
        logic show_timer_done;
        logic last_round;
        logic note_pressed;
        logic note_right;
        logic timing_right;
        logic beat_low;
        logic address_is_round;
        logic timeout;
        logic song_end;
    } play_status_t;

    typedef struct packed {
        logic       clear_registers;
        logic       clear_options;
        logic       open_menu;
        logic       show_menu;
        logic [1:0] menu_page;
        logic       load_mode;
        logic       load_bpm;
        logic       load_key;
        logic       load_song;
    } menu_ctrl_t;

    typedef struct packed {
        logic clear_note;
        logic count_note;
        logic clear_show_timer;
        logic count_show_timer;
        logic clear_round;
        logic count_round;
        logic clear_beat;
        logic count_beat;
        logic clear_reply_timer;
        logic count_reply_timer;
        logic latch_note;
        logic leds_from_memory;
        logic leds_on;
        logic sound;
        logic open_error_menu;
        logic error_menu_shown;
        logic latch_error;
        logic won;
        logic lost;
        logic player_turn;
    } play_ctrl_t;

endpackage

//--- sources.f
hdl/piano_ctrl_pkg.sv
hdl/menu_sequencer.sv
hdl/game_sequencer.sv
hdl/piano_control_unit.sv
tests/game_sequencer_properties.sv
tests/piano_checker.sv
tests/tb_piano_control_unit.sv

//--- tests/game_sequencer_properties.sv
// ----------------------------------------
// Game sequencer assertions
// ----------------------------------------
`timescale 1ns/1ps

module game_sequencer_properties (
    input  logic                        clock,
    input  logic                        reset,
    input  piano_ctrl_pkg::play_ctrl_t  play_ctrl,
    input  piano_ctrl_pkg::state_code_t game_state,
    input  logic                        game_done
);

    int failures = 0;

    result_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(play_ctrl.won && play_ctrl.lost))
        else begin
            failures++;
            $error("won and lost are high in the same cycle");
        end

    // Hand-back to the menu is a single pulse
    done_single_cycle: assert property (@(posedge clock) disable iff (reset)
        game_done |=> !game_done)
        else begin
            failures++;
            $error("game_done stayed high for more than one cycle");
        end

    turn_only_in_wait_note: assert property (@(posedge clock) disable iff (reset)
        play_ctrl.player_turn |-> (game_state == piano_ctrl_pkg::ST_WAIT_NOTE))
        else begin
            failures++;
            $error("player_turn is high outside wait_note, state %h", game_state);
        end

endmodule

bind game_sequencer game_sequencer_properties game_checks (
    .clock      (clock),
    .reset      (reset),
    .play_ctrl  (play_ctrl),
    .game_state (game_state),
    .game_done  (game_done)
);

//--- tests/piano_checker.sv
// ----------------------------------------
// Piano control step checker
// ----------------------------------------
`timescale 1ns/1ps

module piano_checker (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        check_valid,
    input  logic [127:0]                step_name,
    input  piano_ctrl_pkg::state_code_t exp_state,
    input  logic [3:0]                  exp_flags,
    input  piano_ctrl_pkg::state_code_t db_state,
    input  piano_ctrl_pkg::menu_ctrl_t  menu_ctrl,
    input  piano_ctrl_pkg::play_ctrl_t  play_ctrl,
    output int                          pass_count,
    output int                          fail_count
);

    logic                        held_valid;
    logic [127:0]                held_name;
    piano_ctrl_pkg::state_code_t held_state;
    logic [3:0]                  held_flags;
    logic [3:0]                  act_flags;
    logic [2:0]                  page_exp;
    piano_ctrl_pkg::menu_ctrl_t  idle_menu;

    // Bit 2 marks a setup page, low bits give the page shown
    function automatic logic [2:0] expected_page(input logic [5:0] code);
        case (code)
            6'h1D:   expected_page = 3'b100;
            6'h1E:   expected_page = 3'b101;
            6'h1F:   expected_page = 3'b110;
            6'h20:   expected_page = 3'b111;
            default: expected_page = 3'b000;
        endcase
    endfunction

    // Row applied at one edge is seen after the next
    always @(posedge clock) begin
        held_valid <= check_valid;
        held_name  <= step_name;
        held_state <= exp_state;
        held_flags <= exp_flags;
    end

    always @(negedge clock) begin
        if (reset) begin
            pass_count = 0;
            fail_count = 0;
        end else if (held_valid) begin
            // Flags are won, lost, sound, player_turn
            act_flags = {play_ctrl.won, play_ctrl.lost, play_ctrl.sound, play_ctrl.player_turn};
            page_exp  = expected_page(held_state);
            idle_menu = '0;
            idle_menu.clear_registers = 1'b1;
            idle_menu.clear_options   = 1'b1;
            if (db_state !== held_state || act_flags !== held_flags) begin
                fail_count++;
                $display("FAIL %s: expected state %h flags %b, actual state %h flags %b",
                         held_name, held_state, held_flags, db_state, act_flags);
            end else if (page_exp[2] && (menu_ctrl.show_menu !== 1'b1 ||
                                         menu_ctrl.menu_page !== page_exp[1:0])) begin
                fail_count++;
                $display("FAIL %s: expected menu_page %0d, actual %0d (show_menu %b)",
                         held_name, page_exp[1:0], menu_ctrl.menu_page, menu_ctrl.show_menu);
            end else if (held_state == 6'h00 && (play_ctrl !== '0 || menu_ctrl !== idle_menu)) begin
                fail_count++;
                $display("FAIL %s: expected play_ctrl %h menu_ctrl %h, actual %h %h",
                         held_name, 20'h0, idle_menu, play_ctrl, menu_ctrl);
            end else begin
                pass_count++;
                $display("pass %s: state %h", held_name, db_state);
            end
        end
    end

endmodule

//--- tests/tb_piano_control_unit.sv
// ----------------------------------------
// Piano control unit testbench
// ----------------------------------------
`timescale 1ns/1ps

module tb_piano_control_unit;

    typedef struct packed {
        logic [127:0]                 name;
        logic                         start;
        logic                         enter;
        piano_ctrl_pkg::play_mode_t   mode;
        piano_ctrl_pkg::err_choice_t  err_choice;
        piano_ctrl_pkg::play_status_t status;
        piano_ctrl_pkg::state_code_t  exp_state;
        logic [3:0]                   exp_flags;
    } step_t;

    logic                         clock = 1'b0;
    logic                         reset;
    logic                         start;
    logic                         enter;
    piano_ctrl_pkg::play_mode_t   mode;
    piano_ctrl_pkg::err_choice_t  err_choice;
    piano_ctrl_pkg::play_status_t status;
    piano_ctrl_pkg::menu_ctrl_t   menu_ctrl;
    piano_ctrl_pkg::play_ctrl_t   play_ctrl;
    piano_ctrl_pkg::state_code_t  db_state;

    logic                         check_valid;
    logic [127:0]                 check_name;
    piano_ctrl_pkg::state_code_t  check_state;
    logic [3:0]                   check_flags;
    int                           pass_count;
    int                           fail_count;
    int                           table_rows = 0;
    step_t                        steps[$];

    always #20 clock = ~clock;

    piano_control_unit uut (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .enter      (enter),
        .mode       (mode),
        .err_choice (err_choice),
        .status     (status),
        .menu_ctrl  (menu_ctrl),
        .play_ctrl  (play_ctrl),
        .db_state   (db_state)
    );

    piano_checker step_check (
        .clock       (clock),
        .reset       (reset),
        .check_valid (check_valid),
        .step_name   (check_name),
        .exp_state   (check_state),
        .exp_flags   (check_flags),
        .db_state    (db_state),
        .menu_ctrl   (menu_ctrl),
        .play_ctrl   (play_ctrl),
        .pass_count  (pass_count),
        .fail_count  (fail_count)
    );

    initial begin
        reset       = 1'b1;
        start       = 1'b0;
        enter       = 1'b0;
        mode        = '0;
        err_choice  = '0;
        status      = '0;
        check_valid = 1'b0;
        // name, start, enter, mode {free,genius}, err {round,note,last},
        // status {timer,last,pressed,right,timing,beat,round,timeout,end},
        // db_state, {won,lost,sound,turn}
        steps = '{
            '{"idle",          1'b0, 1'b0, 2'b00, 3'b000, 9'h000, 6'h00, 4'b0000},
            '{"start",         1'b1, 1'b0, 2'b00, 3'b000, 9'h000, 6'h1C, 4'b0000},
            '{"open_menu",     1'b0, 1'b0, 2'b00, 3'b000, 9'h000, 6'h1D, 4'b0000},
            '{"mode_page",     1'b0, 1'b1, 2'b01, 3'b000, 9'h000, 6'h1E, 4'b0000},
            '{"tempo_page",    1'b0, 1'b1, 2'b01, 3'b000, 9'h000, 6'h1F, 4'b0000},
            '{"key_page",      1'b0, 1'b1, 2'b01, 3'b000, 9'h000, 6'h20, 4'b0000},
            '{"song_page",     1'b0, 1'b1, 2'b01, 3'b000, 9'h000, 6'h3F, 4'b0000},
            '{"game_init",     1'b0, 1'b0, 2'b01, 3'b000, 9'h000, 6'h01, 4'b0000},
            '{"round_start",   1'b0, 1'b0, 2'b01, 3'b000, 9'h000, 6'h02, 4'b0000},
            '{"timer_done",    1'b0, 1'b0, 2'b01, 3'b000, 9'h100, 6'h03, 4'b0000},
            '{"show",          1'b0, 1'b0, 2'b01, 3'b000, 9'h000, 6'h04, 4'b0000},
            '{"beat_round",    1'b0, 1'b0, 2'b01, 3'b000, 9'h00C, 6'h06, 4'b0000},
            '{"note_start",    1'b0, 1'b0, 2'b01, 3'b000, 9'h000, 6'h07, 4'b0001},
            '{"press",         1'b0, 1'b0, 2'b01, 3'b000, 9'h040, 6'h17, 4'b0010},
            '{"release",       1'b0, 1'b0, 2'b01, 3'b000, 9'h000, 6'h09, 4'b0000},
            '{"wrong_note",    1'b0, 1'b0, 2'b01, 3'b000, 9'h000, 6'h14, 4'b0100},
            '{"open_error",    1'b0, 1'b0, 2'b01, 3'b000, 9'h000, 6'h21, 4'b0000},
            '{"error_menu",    1'b0, 1'b0, 2'b01, 3'b000, 9'h000, 6'h22, 4'b0000},
            '{"no_choice",     1'b0, 1'b1, 2'b01, 3'b000, 9'h000, 6'h22, 4'b0000},
            '{"retry_note",    1'b0, 1'b1, 2'b01, 3'b010, 9'h000, 6'h06, 4'b0000},
            '{"note_start2",   1'b0, 1'b0, 2'b01, 3'b000, 9'h000, 6'h07, 4'b0001},
            '{"timeout_press", 1'b0, 1'b0, 2'b01, 3'b000, 9'h042, 6'h15, 4'b0100},
            '{"open_error2",   1'b0, 1'b0, 2'b01, 3'b000, 9'h000, 6'h21, 4'b0000},
            '{"error_menu2",   1'b0, 1'b0, 2'b01, 3'b000, 9'h000, 6'h22, 4'b0000},
            '{"replay_last",   1'b0, 1'b1, 2'b01, 3'b001, 9'h000, 6'h18, 4'b0000},
            '{"last_beat",     1'b0, 1'b0, 2'b01, 3'b000, 9'h008, 6'h07, 4'b0001},
            '{"press2",        1'b0, 1'b0, 2'b01, 3'b000, 9'h040, 6'h17, 4'b0010},
            '{"release2",      1'b0, 1'b0, 2'b01, 3'b000, 9'h000, 6'h09, 4'b0000},
            '{"round_won",     1'b0, 1'b0, 2'b01, 3'b000, 9'h0B4, 6'h0A, 4'b1000},
            '{"won_start",     1'b1, 1'b0, 2'b01, 3'b000, 9'h000, 6'h3E, 4'b0000},
            '{"finish",        1'b0, 1'b0, 2'b01, 3'b000, 9'h000, 6'h1C, 4'b0000},
            '{"open_menu2",    1'b0, 1'b0, 2'b10, 3'b000, 9'h000, 6'h1D, 4'b0000},
            '{"free_mode",     1'b0, 1'b1, 2'b10, 3'b000, 9'h000, 6'h1E, 4'b0000},
            '{"free_tempo",    1'b0, 1'b1, 2'b10, 3'b000, 9'h000, 6'h1F, 4'b0000},
            '{"free_key",      1'b0, 1'b1, 2'b10, 3'b000, 9'h000, 6'h3F, 4'b0000},
            '{"free_init",     1'b0, 1'b0, 2'b10, 3'b000, 9'h000, 6'h01, 4'b0000},
            '{"free_wait",     1'b0, 1'b0, 2'b10, 3'b000, 9'h000, 6'h23, 4'b0000},
            '{"free_press",    1'b0, 1'b0, 2'b10, 3'b000, 9'h040, 6'h17, 4'b0010},
            '{"free_release",  1'b0, 1'b0, 2'b10, 3'b000, 9'h000, 6'h23, 4'b0000}
        };
        table_rows = steps.size();
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        for (int row = 0; row < table_rows; row++) begin
            @(posedge clock);
            start       <= steps[row].start;
            enter       <= steps[row].enter;
            mode        <= steps[row].mode;
            err_choice  <= steps[row].err_choice;
            status      <= steps[row].status;
            check_name  <= steps[row].name;
            check_state <= steps[row].exp_state;
            check_flags <= steps[row].exp_flags;
            check_valid <= 1'b1;
        end
        @(posedge clock);
        check_valid <= 1'b0;
        @(posedge clock);
        $display("Steps %0d, passed %0d, failed %0d, assertion failures %0d",
                 table_rows, pass_count, fail_count, uut.game_seq.game_checks.failures);
        if (fail_count == 0 && pass_count == table_rows &&
            uut.game_seq.game_checks.failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Four cycles per step plus the reset time
    initial begin
        wait (table_rows > 0);
        #(table_rows * 160 + 400);
        $display("Timeout: the run did not finish within %0d ns", table_rows * 160 + 400);
        $display("TB FAILED");
        $finish;
    end

endmodule
